// ==== design/dsiq_config.svh ====
`ifndef DSIQ_CONFIG_SVH
`define DSIQ_CONFIG_SVH

// ==============================
// Buffer sizing
// ==============================

// Number of IQ words the buffer holds. Must be a power of two.
`define DSIQ_DEPTH 64

// Fill level runs from zero to full, so it needs one bit more than the address.
`define DSIQ_LEVEL_W ($clog2(`DSIQ_DEPTH) + 1)

// Threshold for both the admit and the release hysteresis.
`define DSIQ_HALF (`DSIQ_DEPTH / 2)

`endif

// ==== design/dsiq_pkg.sv ====
`default_nettype none

`include "dsiq_config.svh"

package dsiq_pkg;

  // ==============================
  // Stream payloads
  // ==============================

  // One byte from the Ethernet receiver.
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  // Big-endian sample pair, I in the upper half.
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_word_t;

  typedef struct packed {
    iq_word_t word;
    logic     last;
  } word_beat_t;

  // Write side admission and read side release.
  typedef enum logic {ADMIT, DROP} admit_state_t;
  typedef enum logic {PRIMING, DRAINING} fill_state_t;

endpackage

`default_nettype wire

// ==== design/dsiq_byte_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsiq_byte_packer
  import dsiq_pkg::*;
(
  input  logic       rd_clk,
  input  logic       rst,
  input  logic       in_valid,
  input  byte_beat_t in_beat,
  output logic       pk_valid,
  output word_beat_t pk_beat
);

  logic [1:0]  byte_cnt;
  logic [31:0] hold;
  logic        word_last;
  logic        fourth;

  // The byte now on the input completes a word.
  assign fourth = in_valid && (byte_cnt == 2'd3);

  // ==============================
  // Control
  // ==============================

  // A packet end always restarts the count, so a short tail
  // is simply never emitted.
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      byte_cnt <= 2'd0;
      pk_valid <= 1'b0;
    end else begin
      pk_valid <= fourth;
      if (in_valid) begin
        if (in_beat.last) begin
          byte_cnt <= 2'd0;
        end else begin
          byte_cnt <= byte_cnt + 2'd1;
        end
      end
    end
  end

  // ==============================
  // Data
  // ==============================

  // First byte ends up in bits 31:24, which is I high byte.
  always_ff @(posedge rd_clk) begin
    if (in_valid) begin
      hold <= {hold[23:0], in_beat.data};
    end
    if (fourth) begin
      word_last <= in_beat.last;
    end
  end

  // Hold is stable for the cycle pk_valid is high.
  assign pk_beat.word = hold;
  assign pk_beat.last = word_last;

endmodule

`default_nettype wire

// ==== design/dsiq_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsiq_config.svh"

module dsiq_buffer
  import dsiq_pkg::*;
(
  input  logic                     rd_clk,
  input  logic                     rst,
  input  logic                     pk_valid,
  input  word_beat_t               pk_beat,
  output logic                     bf_valid,
  output iq_word_t                 bf_word,
  input  logic                     bf_ready,
  output logic [`DSIQ_LEVEL_W-1:0] level
);

  localparam int ADDR_W = `DSIQ_LEVEL_W - 1;
  localparam logic [`DSIQ_LEVEL_W-1:0] FULL_LEVEL = `DSIQ_LEVEL_W'(`DSIQ_DEPTH);
  localparam logic [`DSIQ_LEVEL_W-1:0] HALF_LEVEL = `DSIQ_LEVEL_W'(`DSIQ_HALF);

  iq_word_t ram [`DSIQ_DEPTH];

  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic              full;
  logic              empty;
  logic              store;
  logic              pop;

  admit_state_t admit_state;
  fill_state_t  fill_state;

  assign full  = (level == FULL_LEVEL);
  assign empty = (level == '0);
  assign store = pk_valid && (admit_state == ADMIT) && !full;
  assign pop   = bf_valid && bf_ready;

  // ==============================
  // Write side
  // ==============================

  // Once a word is lost to a full buffer, the rest of that packet is
  // useless, so drop until a packet end finds room for a whole one.
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      admit_state <= ADMIT;
    end else if (pk_valid) begin
      case (admit_state)
        ADMIT: begin
          if (full) begin
            admit_state <= DROP;
          end
        end
        DROP: begin
          if (pk_beat.last && (level <= HALF_LEVEL)) begin
            admit_state <= ADMIT;
          end
        end
        default: admit_state <= ADMIT;
      endcase
    end
  end

  always_ff @(posedge rd_clk) begin
    if (store) begin
      ram[wr_ptr] <= pk_beat.word;
    end
  end

  // ==============================
  // Pointers and level
  // ==============================

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (store) begin
        wr_ptr <= wr_ptr + ADDR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ADDR_W'(1);
      end
      case ({store, pop})
        2'b10:   level <= level + `DSIQ_LEVEL_W'(1);
        2'b01:   level <= level - `DSIQ_LEVEL_W'(1);
        default: level <= level;
      endcase
    end
  end

  // ==============================
  // Read side
  // ==============================

  // After an underflow, wait for half a buffer of margin before
  // the modulator sees samples again.
  always_ff @(posedge rd_clk) begin
    if (rst) begin
      fill_state <= PRIMING;
    end else begin
      case (fill_state)
        PRIMING: begin
          if (level >= HALF_LEVEL) begin
            fill_state <= DRAINING;
          end
        end
        DRAINING: begin
          if (empty) begin
            fill_state <= PRIMING;
          end
        end
        default: fill_state <= PRIMING;
      endcase
    end
  end

  // Show-ahead read of the head word.
  assign bf_word  = ram[rd_ptr];
  assign bf_valid = (fill_state == DRAINING) && !empty;

endmodule

`default_nettype wire

// ==== design/dsiq_output_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsiq_output_reg
  import dsiq_pkg::*;
(
  input  logic     rd_clk,
  input  logic     rst,
  input  logic     bf_valid,
  input  iq_word_t bf_word,
  output logic     bf_ready,
  output logic     out_valid,
  output iq_word_t out_word,
  input  logic     out_ready
);

  logic     slot_valid;
  iq_word_t slot_word;
  logic     take;

  // Room when empty, or when the current word leaves this cycle.
  assign bf_ready = !slot_valid || out_ready;
  assign take     = bf_valid && bf_ready;

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      slot_valid <= 1'b0;
    end else if (bf_ready) begin
      slot_valid <= bf_valid;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (take) begin
      slot_word <= bf_word;
    end
  end

  // ==============================
  // Modulator side
  // ==============================

  // An idle slot reads as silence, not as a stale sample.
  assign out_valid = slot_valid;
  assign out_word  = slot_valid ? slot_word : '0;

endmodule

`default_nettype wire

// ==== design/dsiq_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsiq_config.svh"

module dsiq_path
  import dsiq_pkg::*;
(
  input  logic                     rd_clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  byte_beat_t               in_beat,
  output logic                     out_valid,
  output iq_word_t                 out_word,
  input  logic                     out_ready,
  output logic [`DSIQ_LEVEL_W-1:0] level
);

  logic       pk_valid;
  word_beat_t pk_beat;
  logic       bf_valid;
  iq_word_t   bf_word;
  logic       bf_ready;

  // Bytes to words.
  dsiq_byte_packer u_packer (
    .rd_clk   (rd_clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .pk_valid (pk_valid),
    .pk_beat  (pk_beat)
  );

  dsiq_buffer u_buffer (
    .rd_clk   (rd_clk),
    .rst      (rst),
    .pk_valid (pk_valid),
    .pk_beat  (pk_beat),
    .bf_valid (bf_valid),
    .bf_word  (bf_word),
    .bf_ready (bf_ready),
    .level    (level)
  );

  // Registered slice towards the modulator.
  dsiq_output_reg u_output_reg (
    .rd_clk    (rd_clk),
    .rst       (rst),
    .bf_valid  (bf_valid),
    .bf_word   (bf_word),
    .bf_ready  (bf_ready),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_dsiq_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsiq_config.svh"

module tb_dsiq_path
  import dsiq_pkg::*;
();

  localparam int PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  localparam int PACK_CYCLES = 320;
  localparam int PRIME_CYCLES = 420;
  localparam int OVERFLOW_CYCLES = 660;
  localparam int BACKPRESSURE_CYCLES = 300;
  localparam int TEST_CYCLES = 5 * RESET_CYCLES + PACK_CYCLES + PRIME_CYCLES
                               + OVERFLOW_CYCLES + BACKPRESSURE_CYCLES;
  localparam logic [`DSIQ_LEVEL_W-1:0] FULL_LEVEL = `DSIQ_LEVEL_W'(`DSIQ_DEPTH);
  localparam logic [`DSIQ_LEVEL_W-1:0] HALF_LEVEL = `DSIQ_LEVEL_W'(`DSIQ_HALF);

  logic                     rd_clk;
  logic                     rst;
  logic                     in_valid;
  byte_beat_t               in_beat;
  logic                     out_valid;
  iq_word_t                 out_word;
  logic                     out_ready;
  logic [`DSIQ_LEVEL_W-1:0] level;

  // Reference model state.
  iq_word_t   exp_q[$];
  logic [7:0] word_bytes [4];
  int         byte_cnt;
  logic       pending;
  iq_word_t   pending_word;
  logic       pending_last;
  logic       dropping;
  logic       random_ready;
  logic       ready_level;
  logic       expect_idle;
  logic       hold_seen = 1'b0;
  iq_word_t   held_word;

  dsiq_path dut (
    .rd_clk    (rd_clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_ready (out_ready),
    .level     (level)
  );

  initial begin
    rd_clk = 1'b0;
    forever #(PERIOD / 2) rd_clk = ~rd_clk;
  end

  initial begin
    #(TEST_CYCLES * 2 * PERIOD);
    report_failure("Watchdog expired before the tests finished.");
  end

  // ==============================
  // Checks
  // ==============================

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Stopping at first error.");
  endtask

  task automatic check_word(input iq_word_t got, input iq_word_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_level(input logic [`DSIQ_LEVEL_W-1:0] got,
                             input logic [`DSIQ_LEVEL_W-1:0] exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // Output monitor. Values at the falling edge equal those at the next rising edge.
  always @(negedge rd_clk) begin
    if (rst) begin
      hold_seen = 1'b0;
    end else begin
      if (hold_seen) begin
        check_valid(out_valid, 1'b1, "out_valid under back-pressure");
        check_word(out_word, held_word, "out_word under back-pressure");
      end
      if (expect_idle) begin
        check_valid(out_valid, 1'b0, "out_valid while priming");
      end
      if (!out_valid) begin
        check_word(out_word, '0, "out_word while not valid");
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("The DUT delivered a word that was never expected.");
        end
        check_word(out_word, exp_q.pop_front(), "output word");
      end
      hold_seen = out_valid && !out_ready;
      held_word = out_word;
    end
  end

  // ==============================
  // Model and stimulus
  // ==============================

  // Bytes 0 and 1 form I, bytes 2 and 3 form Q, high byte first.
  task automatic pack_byte(input logic [7:0] data, input logic last);
    iq_word_t w;
    word_bytes[byte_cnt] = data;
    if (byte_cnt == 3) begin
      w.i = {word_bytes[0], word_bytes[1]};
      w.q = {word_bytes[2], data};
      pending = 1'b1;
      pending_word = w;
      pending_last = last;
    end
    byte_cnt = (last || byte_cnt == 3) ? 0 : byte_cnt + 1;
  endtask

  // The buffer judges a new word by the level it shows in that cycle.
  task automatic admit_word();
    if (pending) begin
      if (!dropping) begin
        if (level == FULL_LEVEL) begin
          dropping = 1'b1;
        end else begin
          exp_q.push_back(pending_word);
        end
      end else if (pending_last && level <= HALF_LEVEL) begin
        dropping = 1'b0;
      end
      pending = 1'b0;
    end
  endtask

  task automatic step(input logic valid, input logic [7:0] data, input logic last);
    @(posedge rd_clk);
    #10;
    in_valid = valid;
    in_beat.data = data;
    in_beat.last = last;
    out_ready = random_ready ? 1'($urandom() % 2) : ready_level;
    @(negedge rd_clk);
    admit_word();
    if (valid) begin
      pack_byte(data, last);
    end
  endtask

  task automatic send_packet(input int nbytes);
    for (int b = 0; b < nbytes; b++) begin
      step(1'b1, 8'($urandom()), b == nbytes - 1);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 8'h00, 1'b0);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 || pending) begin
      if (n == limit) begin
        report_failure("Timed out waiting for the expected words to leave the DUT.");
      end
      step(1'b0, 8'h00, 1'b0);
      n++;
    end
    check_level(level, '0, "level after drain");
  endtask

  task automatic apply_reset();
    @(posedge rd_clk);
    #10;
    rst = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    out_ready = 1'b0;
    exp_q.delete();
    byte_cnt = 0;
    pending = 1'b0;
    dropping = 1'b0;
    random_ready = 1'b0;
    ready_level = 1'b0;
    expect_idle = 1'b0;
    repeat (4) @(posedge rd_clk);
    #10;
    rst = 1'b0;
  endtask

  // ==============================
  // Tests
  // ==============================

  task automatic test_reset();
    apply_reset();
    @(negedge rd_clk);
    check_valid(out_valid, 1'b0, "out_valid after reset");
    check_word(out_word, '0, "out_word after reset");
    check_level(level, '0, "level after reset");
  endtask

  // The short tail packet ends in a partial word that must vanish,
  // so the packet after it starts on a fresh word.
  task automatic test_packing();
    apply_reset();
    ready_level = 1'b1;
    send_packet(4 * `DSIQ_HALF);
    send_packet(4 * 3 + 2);
    send_packet(4 * 2);
    wait_drain(200);
  endtask

  task automatic test_priming();
    apply_reset();
    ready_level = 1'b1;
    for (int round = 0; round < 2; round++) begin
      expect_idle = 1'b1;
      send_packet(4 * (`DSIQ_HALF - 1));
      idle(8);
      expect_idle = 1'b0;
      send_packet(4);
      wait_drain(200);
    end
  endtask

  task automatic test_overflow_drop();
    apply_reset();
    repeat (5) send_packet(`DSIQ_DEPTH);
    idle(2);
    check_level(level, FULL_LEVEL, "level after overflow");
    // First packet is lost at a high level, the second ends near empty.
    ready_level = 1'b1;
    send_packet(`DSIQ_DEPTH / 4);
    send_packet(`DSIQ_DEPTH);
    send_packet(4 * `DSIQ_HALF);
    wait_drain(200);
  endtask

  task automatic test_backpressure();
    apply_reset();
    random_ready = 1'b1;
    send_packet(4 * 20);
    send_packet(4 * 20);
    wait_drain(400);
  endtask

  initial begin
    void'($urandom(32'hc4740580));
    rst = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    out_ready = 1'b0;
    random_ready = 1'b0;
    ready_level = 1'b0;
    expect_idle = 1'b0;
    pending = 1'b0;
    test_reset();
    test_packing();
    test_priming();
    test_overflow_drop();
    test_backpressure();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/dsiq_pkg.sv
design/dsiq_byte_packer.sv
design/dsiq_buffer.sv
design/dsiq_output_reg.sv
design/dsiq_path.sv
testbench/tb_dsiq_path.sv

// ==== Makefile ====
# Verilator build and run of the IQ path testbench.

VERILATOR ?= verilator
TOP       ?= tb_dsiq_path
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed."; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
